// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vesp_cpu
RTL_TOP   ?= vesp_cpu
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RTL_FILES ?= verilog/vesp_pkg.sv verilog/vesp_alu.sv verilog/vesp_registers.sv \
             verilog/vesp_mem_port.sv verilog/vesp_control.sv verilog/vesp_cpu.sv

.PHONY: lint sim build clean

lint:
	$(VERILATOR) --lint-only -sv -Iverilog --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only -sv --timing -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary -sv --timing -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: list.f
+incdir+verilog
verilog/vesp_pkg.sv
verilog/vesp_alu.sv
verilog/vesp_registers.sv
verilog/vesp_mem_port.sv
verilog/vesp_control.sv
verilog/vesp_cpu.sv
verification/vesp_checker.sv
verification/tb_vesp_cpu.sv

// File: verification/tb_vesp_cpu.sv
`timescale 1ns/1ns
`default_nettype none
`include "vesp_config.svh"

module tb_vesp_cpu;
    import vesp_pkg::*;

    localparam int NUM_TESTS = 14;
    localparam int MAX_CYCLES = NUM_TESTS * 16 * 4 * 8;

    // program image of words 0 to 15 for each test.
    localparam logic [15:0] PROGRAMS [NUM_TESTS][16] = '{
        '{16'h2000, 16'h0005, 16'h2001, 16'hFFFB, 16'h0000, 16'h5008, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'h2000, 16'h0003, 16'h2001, 16'h0004, 16'h0000, 16'h5008, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'h2000, 16'hFFFF, 16'h2001, 16'h0000, 16'h1000, 16'h5008, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'h2000, 16'hFFFF, 16'h2001, 16'h0000, 16'h8000, 16'h5008, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'h2000, 16'h0001, 16'h2001, 16'h0000, 16'h9000, 16'h5008, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'h2000, 16'h00F0, 16'h2001, 16'h0F0F, 16'hA000, 16'h5008, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'h2000, 16'h0000, 16'h2001, 16'h8000, 16'hB000, 16'h6008, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'h2000, 16'h4000, 16'h2001, 16'h0000, 16'hC000, 16'h6008, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'h2000, 16'h8000, 16'h2001, 16'h0000, 16'hD000, 16'h6008, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'h4005, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'h8000, 16'h3000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000},
        '{16'hF00A, 16'hE00E, 16'hE00F, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h000C, 16'h7000, 16'h1234, 16'hABCD, 16'h7000, 16'h7000},
        '{16'h2003, 16'h000B, 16'hE00F, 16'h7000, 16'h7000, 16'h7000, 16'h7000, 16'h7000,
          16'h7000, 16'h7000, 16'h7000, 16'h5A5A, 16'h7000, 16'h7000, 16'h7000, 16'h7000}
    };

    // add, add, cmp, inc, dec, and, ior, shl, shr, jmp, hlt, illegal, mxt/mxf, lda ix/mxf.
    localparam logic [11:0] EXP_HALT [NUM_TESTS] = '{
        12'd8, 12'd6, 12'd8, 12'd8, 12'd8, 12'd8, 12'd8,
        12'd8, 12'd6, 12'd5, 12'd0, 12'd1, 12'd3, 12'd3
    };
    localparam logic [1:0] EXP_WR_N [NUM_TESTS] = '{
        2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd2, 2'd1
    };
    localparam logic [11:0] EXP_WR_ADDR [NUM_TESTS][2] = '{
        '{12'd0, 12'd0}, '{12'd0, 12'd0}, '{12'd0, 12'd0}, '{12'd0, 12'd0},
        '{12'd0, 12'd0}, '{12'd0, 12'd0}, '{12'd0, 12'd0}, '{12'd0, 12'd0},
        '{12'd0, 12'd0}, '{12'd0, 12'd0}, '{12'd0, 12'd0}, '{12'd0, 12'd0},
        '{12'd14, 12'd15}, '{12'd15, 12'd0}
    };
    localparam logic [15:0] EXP_WR_DATA [NUM_TESTS][2] = '{
        '{16'h0, 16'h0}, '{16'h0, 16'h0}, '{16'h0, 16'h0}, '{16'h0, 16'h0},
        '{16'h0, 16'h0}, '{16'h0, 16'h0}, '{16'h0, 16'h0}, '{16'h0, 16'h0},
        '{16'h0, 16'h0}, '{16'h0, 16'h0}, '{16'h0, 16'h0}, '{16'h0, 16'h0},
        '{16'h1234, 16'hABCD}, '{16'h5A5A, 16'h0}
    };

    logic                  clk;
    logic                  rst = 1'b0;
    logic                  mem_req;
    logic                  mem_ack = 1'b0;
    logic [`VESP_WORD-1:0] mem_rdata = '0;
    mem_req_t              mem;
    logic                  halted;

    logic                  test_end = 1'b0;
    logic [7:0]            test_num = '0;
    logic [1:0]            exp_count = '0;
    logic [1:0][11:0]      exp_addr = '0;
    logic [1:0][15:0]      exp_data = '0;
    logic [11:0]           exp_halt = '0;
    logic [15:0]           error_count;
    logic [15:0]           fail_count;

    logic [15:0] memory [0:4095];
    logic [31:0] lcg_state = 32'ha74f;
    int          ack_delay = 0;
    logic        waiting = 1'b0;
    int          cycles = 0;

    vesp_cpu u_vesp_cpu (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .mem(mem), .halted(halted)
    );

    vesp_checker u_checker (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_ack(mem_ack), .mem(mem), .halted(halted),
        .test_end(test_end), .test_num(test_num),
        .exp_count(exp_count), .exp_addr(exp_addr), .exp_data(exp_data),
        .exp_halt(exp_halt),
        .error_count(error_count), .fail_count(fail_count)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // unused words hold hlt with the low address bits as operand.
    task automatic load_memory(input int t);
        for (int i = 0; i < 4096; i++) begin
            memory[i] = {4'h7, i[11:0]};
        end
        for (int i = 0; i < 16; i++) begin
            memory[i] = PROGRAMS[t][i];
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory answers each request with ack after 0 to 3 cycles.
    always @(posedge clk) begin
        #1;
        if (!rst) begin
            mem_ack = 1'b0;
            waiting = 1'b0;
        end else if (mem_ack) begin
            if (!mem_req) mem_ack = 1'b0;
        end else if (mem_req) begin
            if (!waiting) begin
                waiting   = 1'b1;
                ack_delay = int'(lcg_next() >> 16) % 4;
            end
            if (ack_delay == 0) begin
                waiting = 1'b0;
                mem_ack = 1'b1;
                if (mem.write) begin
                    memory[mem.addr] = mem.wdata;
                end else begin
                    mem_rdata = memory[mem.addr];
                end
            end else begin
                ack_delay--;
            end
        end
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: cpu did not halt within %0d cycles", MAX_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge clk);
            #1;
            rst       = 1'b0;
            test_num  = t[7:0];
            exp_count = EXP_WR_N[t];
            exp_addr  = {EXP_WR_ADDR[t][1], EXP_WR_ADDR[t][0]};
            exp_data  = {EXP_WR_DATA[t][1], EXP_WR_DATA[t][0]};
            exp_halt  = EXP_HALT[t];
            load_memory(t);
            repeat (10) @(posedge clk);
            #1 rst = 1'b1;
            while (!halted) @(posedge clk);
            #1 test_end = 1'b1;
            @(posedge clk);
            #1 test_end = 1'b0;
        end
        @(posedge clk);
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, fail_count, error_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/vesp_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "vesp_config.svh"

module vesp_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_req,
    input  logic               mem_ack,
    input  vesp_pkg::mem_req_t mem,
    input  logic               halted,
    input  logic               test_end,
    input  logic [7:0]         test_num,
    input  logic [1:0]         exp_count,
    input  logic [1:0][11:0]   exp_addr,
    input  logic [1:0][15:0]   exp_data,
    input  logic [11:0]        exp_halt,
    output logic [15:0]        error_count,
    output logic [15:0]        fail_count
);
    import vesp_pkg::*;

    logic                  prev_req = 1'b0;
    logic                  prev_ack = 1'b0;
    mem_req_t              prev_mem = '0;
    logic [`VESP_ADDR-1:0] last_read = '0; // address of the latest read, the halting fetch at the end.
    int                    wr_count = 0;
    int                    test_errors = 0;
    int                    errors = 0;
    int                    fails = 0;

    assign error_count = errors[15:0];
    assign fail_count  = fails[15:0];

    task automatic count_error();
        test_errors++;
        errors++;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            prev_req    = 1'b0;
            prev_ack    = 1'b0;
            wr_count    = 0;
            last_read   = '0;
            test_errors = 0;
        end else begin
            if (prev_req && mem_req && mem != prev_mem) begin
                $display("request fields changed while req was high at %0t", $time);
                count_error();
            end
            if (prev_req && !mem_req && !prev_ack) begin
                $display("req dropped before ack was seen at %0t", $time);
                count_error();
            end
            if (mem_req && !prev_req) begin
                if (!mem.write) begin
                    last_read = mem.addr;
                end else if (wr_count >= int'(exp_count)) begin
                    $display("unexpected extra write to address %h at %0t", mem.addr, $time);
                    count_error();
                end else begin
                    if (mem.addr != exp_addr[wr_count] || mem.wdata != exp_data[wr_count]) begin
                        $display("error at %0t: write %0d went to %h with %h, expected %h with %h",
                                 $time, wr_count, mem.addr, mem.wdata,
                                 exp_addr[wr_count], exp_data[wr_count]);
                        count_error();
                    end
                    wr_count++;
                end
            end
            if (test_end) begin
                if (!halted) begin
                    $display("cpu did not halt in test %0d", test_num);
                    count_error();
                end
                if (wr_count < int'(exp_count)) begin
                    $display("missing writes in test %0d, saw %0d of %0d",
                             test_num, wr_count, exp_count);
                    count_error();
                end
                if (last_read != exp_halt) begin
                    $display("error at %0t: halted at %h, expected %h", $time, last_read, exp_halt);
                    count_error();
                end
                if (test_errors == 0) begin
                    $display("test %0d passed", test_num);
                end else begin
                    fails++;
                    $display("test %0d failed with %0d errors", test_num, test_errors);
                end
            end
            prev_req = mem_req;
            prev_ack = mem_ack;
            prev_mem = mem;
        end
    end

endmodule

`default_nettype wire

// File: verilog/vesp_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "vesp_config.svh"

module vesp_alu (
    input  logic [`VESP_WORD-1:0] a,
    input  logic [`VESP_WORD-1:0] b,
    input  vesp_pkg::opcode_e     opcode,
    output logic [`VESP_WORD-1:0] result,
    output logic                  zero,
    output logic                  sign
);
    import vesp_pkg::*;

    always_comb begin
        case (opcode)
            ADD:     result = a + b;
            CMP:     result = ~a;
            INC:     result = a + 1'b1;
            DEC:     result = a - 1'b1;
            AND:     result = a & b;
            IOR:     result = a | b;
            SHL:     result = a << 1;
            SHR:     result = a >> 1; // logical shift.
            default: result = '0;
        endcase
    end

    // flags come straight from a, tested during decode.
    assign zero = (a == '0);
    assign sign = a[`VESP_WORD-1];

endmodule

`default_nettype wire

// File: verilog/vesp_config.svh
`ifndef VESP_CONFIG_SVH
`define VESP_CONFIG_SVH

// datapath widths.
`define VESP_WORD    16
`define VESP_OPCODE  4
`define VESP_OPERAND 12
`define VESP_ADDR    12

// register codes carried in the LDA operand field.
`define VESP_REG_A   12'd0
`define VESP_REG_B   12'd1
`define VESP_REG_IX  12'd3

`endif

// File: verilog/vesp_control.sv
`timescale 1ns/1ns
`default_nettype none
`include "vesp_config.svh"

module vesp_control (
    input  logic                     clk,
    input  logic                     rst,
    input  vesp_pkg::opcode_e        opcode,
    input  logic [`VESP_OPERAND-1:0] operand,
    input  logic                     zero,
    input  logic                     sign,
    input  logic                     mem_done,
    output vesp_pkg::ctrl_t          ctrl,
    output vesp_pkg::mem_cmd_t       cmd,
    output logic                     halted
);
    import vesp_pkg::*;

    state_e state, next_state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign halted = (state == S_HALT);

    always_comb begin
        next_state   = state;
        ctrl         = '0;
        ctrl.bus_src = BUS_MDR;
        cmd          = '0;
        cmd.addr_src = ADDR_PC;

        case (state)
            S_IDLE: next_state = S_FETCH;

            S_FETCH: begin
                cmd.start  = 1'b1; // read at pc.
                next_state = S_FETCH_WAIT;
            end

            S_FETCH_WAIT: begin
                if (mem_done) begin
                    ctrl.load_ir = 1'b1;
                    ctrl.inc_pc  = 1'b1;
                    next_state   = S_DECODE;
                end
            end

            S_DECODE: begin
                next_state = S_FETCH;
                case (opcode)
                    ADD, CMP, INC, DEC, AND, IOR, SHL, SHR: begin
                        ctrl.bus_src = BUS_ALU;
                        ctrl.load_a  = 1'b1;
                    end
                    JMP: begin
                        ctrl.bus_src = BUS_OPERAND;
                        ctrl.load_pc = 1'b1;
                    end
                    JEZ: begin
                        ctrl.bus_src = BUS_OPERAND;
                        ctrl.load_pc = zero;
                    end
                    JPS: begin
                        ctrl.bus_src = BUS_OPERAND;
                        ctrl.load_pc = sign;
                    end
                    LDA: begin
                        cmd.start  = 1'b1; // immediate word sits at pc.
                        next_state = S_LDA_WAIT;
                    end
                    MXT: begin
                        cmd.start    = 1'b1;
                        cmd.addr_src = ADDR_OPERAND;
                        next_state   = S_MXT_WAIT;
                    end
                    MXF: begin
                        cmd.start    = 1'b1;
                        cmd.addr_src = ADDR_IX;
                        next_state   = S_MXF_READ_WAIT;
                    end
                    HLT:     next_state = S_HALT;
                    default: next_state = S_HALT; // mov and anything else is illegal.
                endcase
            end

            S_LDA_WAIT: begin
                if (mem_done) begin
                    ctrl.inc_pc = 1'b1; // step over the immediate.
                    next_state  = S_LDA_NEXT;
                end
            end

            S_LDA_NEXT: begin
                next_state = S_FETCH;
                case (operand)
                    `VESP_REG_A:  ctrl.load_a  = 1'b1;
                    `VESP_REG_B:  ctrl.load_b  = 1'b1;
                    `VESP_REG_IX: ctrl.load_ix = 1'b1;
                    default:      ctrl.load_a  = 1'b0;
                endcase
            end

            S_MXT_WAIT: begin
                if (mem_done) begin
                    ctrl.load_ix = 1'b1;
                    next_state   = S_FETCH;
                end
            end

            S_MXF_READ_WAIT: begin
                if (mem_done) begin
                    ctrl.load_ixread = 1'b1;
                    next_state       = S_MXF_WRITE;
                end
            end

            // ix_read now holds mem[ix] and becomes the write data.
            S_MXF_WRITE: begin
                cmd.start    = 1'b1;
                cmd.write    = 1'b1;
                cmd.addr_src = ADDR_OPERAND;
                next_state   = S_MXF_WRITE_WAIT;
            end

            S_MXF_WRITE_WAIT: begin
                if (mem_done) begin
                    ctrl.inc_ix = 1'b1;
                    next_state  = S_FETCH;
                end
            end

            S_HALT: next_state = S_HALT; // only reset leaves.

            default: next_state = S_IDLE;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/vesp_cpu.sv
`timescale 1ns/1ns
`default_nettype none
`include "vesp_config.svh"

module vesp_cpu (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  mem_req,
    input  logic                  mem_ack,
    input  logic [`VESP_WORD-1:0] mem_rdata,
    output vesp_pkg::mem_req_t    mem,
    output logic                  halted
);
    import vesp_pkg::*;

    ctrl_t    ctrl;
    mem_cmd_t cmd;
    opcode_e  opcode;

    logic [`VESP_WORD-1:0]    a, b, ix, ix_read, alu_result, mdr;
    logic [`VESP_ADDR-1:0]    pc;
    logic [`VESP_OPERAND-1:0] operand;
    logic                     zero, sign, mem_done;

    vesp_control u_control (
        .clk(clk), .rst(rst),
        .opcode(opcode), .operand(operand),
        .zero(zero), .sign(sign), .mem_done(mem_done),
        .ctrl(ctrl), .cmd(cmd), .halted(halted)
    );

    vesp_registers u_registers (
        .clk(clk), .rst(rst),
        .ctrl(ctrl), .mdr(mdr), .alu_result(alu_result),
        .a(a), .b(b), .pc(pc), .ix(ix), .ix_read(ix_read),
        .opcode(opcode), .operand(operand)
    );

    vesp_alu u_alu (
        .a(a), .b(b), .opcode(opcode),
        .result(alu_result), .zero(zero), .sign(sign)
    );

    vesp_mem_port u_mem_port (
        .clk(clk), .rst(rst),
        .cmd(cmd), .pc(pc), .ix(ix), .operand(operand), .ix_read(ix_read),
        .mdr(mdr), .mem_done(mem_done),
        .mem_req(mem_req), .mem_ack(mem_ack), .mem_rdata(mem_rdata), .mem(mem)
    );

endmodule

`default_nettype wire

// File: verilog/vesp_mem_port.sv
`timescale 1ns/1ns
`default_nettype none
`include "vesp_config.svh"

module vesp_mem_port (
    input  logic                     clk,
    input  logic                     rst,
    input  vesp_pkg::mem_cmd_t       cmd,
    input  logic [`VESP_ADDR-1:0]    pc,
    input  logic [`VESP_WORD-1:0]    ix,
    input  logic [`VESP_OPERAND-1:0] operand,
    input  logic [`VESP_WORD-1:0]    ix_read,
    output logic [`VESP_WORD-1:0]    mdr,
    output logic                     mem_done,
    output logic                     mem_req,
    input  logic                     mem_ack,
    input  logic [`VESP_WORD-1:0]    mem_rdata,
    output vesp_pkg::mem_req_t       mem
);
    import vesp_pkg::*;

    logic                  busy;
    logic                  write_q;
    logic [`VESP_ADDR-1:0] mar;
    logic [`VESP_ADDR-1:0] addr_sel;
    logic [`VESP_WORD-1:0] wdata;

    always_comb begin
        case (cmd.addr_src)
            ADDR_IX:      addr_sel = ix[`VESP_ADDR-1:0];
            ADDR_OPERAND: addr_sel = operand;
            default:      addr_sel = pc;
        endcase
    end

    // busy with req high waits for ack, busy with req low waits for ack to drop.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy     <= 1'b0;
            mem_req  <= 1'b0;
            mem_done <= 1'b0;
            write_q  <= 1'b0;
            mar      <= '0;
        end else begin
            mem_done <= 1'b0;
            if (!busy) begin
                if (cmd.start) begin
                    busy    <= 1'b1;
                    mem_req <= 1'b1;
                    write_q <= cmd.write;
                    mar     <= addr_sel;
                end
            end else if (mem_req) begin
                if (mem_ack) mem_req <= 1'b0;
            end else if (!mem_ack) begin
                busy     <= 1'b0;
                mem_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && cmd.start) wdata <= ix_read;
        if (busy && mem_req && mem_ack && !write_q) mdr <= mem_rdata; // read data valid with ack.
    end

    assign mem.addr  = mar;
    assign mem.wdata = wdata;
    assign mem.write = write_q;

endmodule

`default_nettype wire

// File: verilog/vesp_pkg.sv
`default_nettype none
`include "vesp_config.svh"

package vesp_pkg;

    typedef enum logic [`VESP_OPCODE-1:0] {
        ADD = 4'd0, CMP = 4'd1, LDA = 4'd2, MOV = 4'd3,
        JMP = 4'd4, JEZ = 4'd5, JPS = 4'd6, HLT = 4'd7,
        INC = 4'd8, DEC = 4'd9, AND = 4'd10, IOR = 4'd11,
        SHL = 4'd12, SHR = 4'd13, MXF = 4'd14, MXT = 4'd15
    } opcode_e;

    typedef enum logic [3:0] {
        S_IDLE, S_FETCH, S_FETCH_WAIT, S_DECODE,
        S_LDA_NEXT, S_LDA_WAIT, S_MXT_WAIT,
        S_MXF_READ_WAIT, S_MXF_WRITE, S_MXF_WRITE_WAIT, S_HALT
    } state_e;

    typedef enum logic [1:0] {BUS_MDR = 2'd0, BUS_ALU = 2'd1, BUS_OPERAND = 2'd2} bus_src_e;

    typedef enum logic [1:0] {ADDR_PC = 2'd0, ADDR_IX = 2'd1, ADDR_OPERAND = 2'd2} addr_src_e;

    typedef struct packed {
        logic     load_a;
        logic     load_b;
        logic     load_ix;
        logic     load_ir;
        logic     load_ixread;
        logic     load_pc;
        logic     inc_pc;
        logic     inc_ix;
        bus_src_e bus_src;
    } ctrl_t;

    typedef struct packed {
        logic      start;
        logic      write;
        addr_src_e addr_src;
    } mem_cmd_t;

    // what the memory sees while req is high.
    typedef struct packed {
        logic [`VESP_ADDR-1:0] addr;
        logic [`VESP_WORD-1:0] wdata;
        logic                  write;
    } mem_req_t;

endpackage

`default_nettype wire

// File: verilog/vesp_registers.sv
`timescale 1ns/1ns
`default_nettype none
`include "vesp_config.svh"

module vesp_registers (
    input  logic                     clk,
    input  logic                     rst,
    input  vesp_pkg::ctrl_t          ctrl,
    input  logic [`VESP_WORD-1:0]    mdr,
    input  logic [`VESP_WORD-1:0]    alu_result,
    output logic [`VESP_WORD-1:0]    a,
    output logic [`VESP_WORD-1:0]    b,
    output logic [`VESP_ADDR-1:0]    pc,
    output logic [`VESP_WORD-1:0]    ix,
    output logic [`VESP_WORD-1:0]    ix_read,
    output vesp_pkg::opcode_e        opcode,
    output logic [`VESP_OPERAND-1:0] operand
);
    import vesp_pkg::*;

    logic [`VESP_WORD-1:0] ir;
    logic [`VESP_WORD-1:0] bus;

    // result bus feeding every register load.
    always_comb begin
        case (ctrl.bus_src)
            BUS_ALU:     bus = alu_result;
            BUS_OPERAND: bus = {{(`VESP_WORD-`VESP_OPERAND){1'b0}}, operand};
            default:     bus = mdr;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            a  <= '0;
            b  <= '0;
            ir <= '0;
        end else begin
            if (ctrl.load_a) a <= bus;
            if (ctrl.load_b) b <= bus;
            if (ctrl.load_ir) ir <= bus;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= '0;
            ix <= '0;
        end else begin
            if (ctrl.load_pc) begin
                pc <= bus[`VESP_ADDR-1:0];
            end else if (ctrl.inc_pc) begin
                pc <= pc + 1'b1;
            end
            if (ctrl.load_ix) begin
                ix <= bus;
            end else if (ctrl.inc_ix) begin
                ix <= ix + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_ixread) ix_read <= bus; // copy of mem[ix] for mxf.
    end

    assign opcode  = opcode_e'(ir[`VESP_WORD-1 -: `VESP_OPCODE]);
    assign operand = ir[`VESP_OPERAND-1:0];

endmodule

`default_nettype wire
